/* div_unit.f */
+incdir+.
div_unit_pkg.sv
div_req_queue.sv
div_operand_prep.sv
iterative_divider.sv
div_result_format.sv
div_unit_top.sv
div_unit_checker.sv
div_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the divide unit testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -f div_unit.f \
	--top-module div_unit_tb -o div_unit_sim
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/div_unit_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi

/* div_unit_tb.sv */
`include "div_unit_defs.svh"

module div_unit_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int total_reqs = 12 + 16 + 12 + 40 + 5 + 8; // requests over all tests
	localparam int timeout_cycles = total_reqs * (64 + 8) + 10 + 500;
	// worst case to empty queue, prep, divider and formatter
	localparam int drain_limit = (`QUEUE_DEPTH + 3) * (64 + 8) * 2;

	logic                  clk = 1'b0;
	logic                  reset;
	logic                  flush;
	logic                  in_valid;
	logic                  in_ready;
	div_unit_pkg::div_op_e in_op;
	logic [`XLEN-1:0]      in_a;
	logic [`XLEN-1:0]      in_b;
	logic [`TAG_W-1:0]     in_tag;
	logic                  out_valid;
	logic                  out_ready = 1'b0;
	logic [`XLEN-1:0]      out_result;
	logic [`TAG_W-1:0]     out_tag;

	logic                  ready_random = 1'b0;
	logic                  ready_level = 1'b1;
	logic [`TAG_W-1:0]     next_tag = '0;

	always #2 clk = ~clk;

	div_unit_top dut_i (.*);

	div_unit_checker chk_i (.*);

	// sink side, random or fixed
	always @(posedge clk) begin
		if (ready_random)
			out_ready <= (($urandom() & 32'd1) != 0);
		else
			out_ready <= ready_level;
	end

	function automatic logic [`XLEN-1:0] rand_operand();
		return {$urandom(), $urandom()};
	endfunction

	// call at a rising edge, returns at the edge where the request transferred
	task automatic send_req(input div_unit_pkg::div_op_e op, input logic [`XLEN-1:0] a,
			input logic [`XLEN-1:0] b);
		in_valid <= 1'b1;
		in_op    <= op;
		in_a     <= a;
		in_b     <= b;
		in_tag   <= next_tag;
		next_tag = next_tag + 1'b1;
		@(negedge clk);
		while (!in_ready)
			@(negedge clk);
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		@(posedge clk);
		while (chk_i.outstanding != 0 && waited < drain_limit) begin
			@(posedge clk);
			waited++;
		end
	endtask

	// ############################################################
	// tests
	// ############################################################
	task automatic directed_cases();
		chk_i.start_test("directed_signs");
		ready_random <= 1'b0;
		send_req(div_unit_pkg::op_divu, 64'd100, 64'd7);
		send_req(div_unit_pkg::op_remu, 64'd100, 64'd7);
		send_req(div_unit_pkg::op_div, -64'sd100, 64'sd7);
		send_req(div_unit_pkg::op_rem, -64'sd100, 64'sd7); // remainder stays negative
		send_req(div_unit_pkg::op_div, 64'sd100, -64'sd7);
		send_req(div_unit_pkg::op_rem, 64'sd100, -64'sd7);
		send_req(div_unit_pkg::op_div, -64'sd100, -64'sd7);
		send_req(div_unit_pkg::op_rem, -64'sd100, -64'sd7);
		send_req(div_unit_pkg::op_divu, '1, 64'd3);
		send_req(div_unit_pkg::op_remu, 64'hfedc_ba98_7654_3210, 64'h0000_0001_0000_0003);
		send_req(div_unit_pkg::op_div, 64'sd1, 64'sd2);
		send_req(div_unit_pkg::op_rem, 64'h8000_0000_0000_0001, 64'sd10);
		wait_drain();
		chk_i.finish_test();
	endtask

	task automatic word_cases();
		logic [31:0] b_lo;
		chk_i.start_test("word_forms");
		ready_random <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			b_lo = $urandom_range(1, 1000);
			if ((i & 4) != 0)
				b_lo = -b_lo;
			send_req(div_unit_pkg::div_op_e'(3'(4 + (i % 4))), rand_operand(), {$urandom(), b_lo});
		end
		wait_drain();
		chk_i.finish_test();
	endtask

	task automatic special_cases();
		chk_i.start_test("special_cases");
		ready_random <= 1'b1;
		send_req(div_unit_pkg::op_div, rand_operand(), '0);
		send_req(div_unit_pkg::op_divu, rand_operand(), '0);
		send_req(div_unit_pkg::op_rem, rand_operand(), '0);
		send_req(div_unit_pkg::op_remu, rand_operand(), '0);
		send_req(div_unit_pkg::op_div, 64'h8000_0000_0000_0000, '1);
		send_req(div_unit_pkg::op_rem, 64'h8000_0000_0000_0000, '1);
		// word divisor zero only in the low half
		send_req(div_unit_pkg::op_divw, rand_operand(), {$urandom(), 32'h0});
		send_req(div_unit_pkg::op_divuw, rand_operand(), {$urandom(), 32'h0});
		send_req(div_unit_pkg::op_remw, rand_operand(), {$urandom(), 32'h0});
		send_req(div_unit_pkg::op_remuw, rand_operand(), {$urandom(), 32'h0});
		send_req(div_unit_pkg::op_divw, {$urandom(), 32'h8000_0000}, {$urandom(), 32'hffff_ffff});
		send_req(div_unit_pkg::op_remw, {$urandom(), 32'h8000_0000}, {$urandom(), 32'hffff_ffff});
		wait_drain();
		chk_i.finish_test();
	endtask

	task automatic random_reqs(input int n);
		logic [`XLEN-1:0] b;
		for (int i = 0; i < n; i++) begin
			b = (($urandom() & 32'd1) != 0) ? rand_operand() : 64'($urandom_range(1, 5000));
			if (i % 13 == 5)
				b = '0;
			send_req(div_unit_pkg::div_op_e'(3'($urandom_range(0, 7))), rand_operand(), b);
		end
	endtask

	task automatic random_burst();
		chk_i.start_test("random_burst");
		ready_random <= 1'b1;
		random_reqs(40);
		wait_drain();
		chk_i.finish_test();
	endtask

	task automatic flush_midway();
		chk_i.start_test("flush_midway");
		ready_random <= 1'b0;
		ready_level  <= 1'b0; // pile work up in queue, prep and divider
		repeat (2) @(posedge clk);
		random_reqs(5);
		repeat (3) @(posedge clk);
		flush <= 1'b1;
		@(posedge clk);
		flush <= 1'b0;
		ready_level <= 1'b1;
		repeat (80) @(posedge clk); // stale results would surface here
		ready_random <= 1'b1;
		random_reqs(8);
		wait_drain();
		chk_i.finish_test();
	endtask

	initial begin
		void'($urandom(83));
		reset    <= 1'b1;
		flush    <= 1'b0;
		in_valid <= 1'b0;
		in_op    <= div_unit_pkg::op_div;
		in_a     <= '0;
		in_b     <= '0;
		in_tag   <= '0;
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		directed_cases();
		word_cases();
		special_cases();
		random_burst();
		flush_midway();
		repeat (5) @(posedge clk);
		chk_i.report_counts();
		if (chk_i.error_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// watchdog
	initial begin
		repeat (timeout_cycles) @(posedge clk);
		$display("run timed out after %0d cycles with results still pending", timeout_cycles);
		$display("Something failed");
		$finish;
	end

endmodule

/* div_unit_checker.sv */
`include "div_unit_defs.svh"

module div_unit_checker (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    flush,
	input  logic                    in_valid,
	input  logic                    in_ready,
	input  div_unit_pkg::div_op_e   in_op,
	input  logic [`XLEN-1:0]        in_a,
	input  logic [`XLEN-1:0]        in_b,
	input  logic [`TAG_W-1:0]       in_tag,
	input  logic                    out_valid,
	input  logic                    out_ready,
	input  logic [`XLEN-1:0]        out_result,
	input  logic [`TAG_W-1:0]       out_tag
);
	timeunit 1ns;
	timeprecision 10ps;

	logic [`XLEN-1:0]  exp_res [$]; // expected results in request order
	logic [`TAG_W-1:0] exp_tag [$];

	string test_name = "none";
	int outstanding = 0;
	int error_count = 0;
	int check_count = 0;
	int test_count = 0;
	int test_checks = 0;
	int test_errors = 0;

	// ############################################################
	// RISC-V M-extension divide rules
	// ############################################################
	function automatic logic [`XLEN-1:0] div_ref(input div_unit_pkg::div_op_e op,
			input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
		logic signed [63:0] sa;
		logic signed [63:0] sb;
		logic signed [63:0] sq;
		logic signed [63:0] sr;
		logic signed [31:0] wa;
		logic signed [31:0] wb;
		logic signed [31:0] wq;
		logic signed [31:0] wr;
		logic [31:0]        w;
		logic [63:0]        r;
		logic               ovf;
		logic               wovf;
		sa   = a;
		sb   = b;
		wa   = a[31:0];
		wb   = b[31:0];
		sq   = '0;
		sr   = '0;
		wq   = '0;
		wr   = '0;
		w    = '0;
		r    = '0;
		ovf  = (a == 64'h8000_0000_0000_0000) && (b == '1);
		wovf = (a[31:0] == 32'h8000_0000) && (b[31:0] == '1);
		// signed quotient and remainder, truncated toward zero
		if (sb != 0 && !ovf) begin
			sq = sa / sb;
			sr = sa % sb;
		end
		if (wb != 0 && !wovf) begin
			wq = wa / wb;
			wr = wa % wb;
		end
		case (op)
			div_unit_pkg::op_div:   r = (b == '0) ? '1 : (ovf ? a : sq);
			div_unit_pkg::op_divu:  r = (b == '0) ? '1 : a / b;
			div_unit_pkg::op_rem:   r = (b == '0) ? a : (ovf ? '0 : sr);
			div_unit_pkg::op_remu:  r = (b == '0) ? a : a % b;
			div_unit_pkg::op_divw:  w = (wb == '0) ? '1 : (wovf ? wa : wq);
			div_unit_pkg::op_divuw: w = (b[31:0] == '0) ? '1 : a[31:0] / b[31:0];
			div_unit_pkg::op_remw:  w = (wb == '0) ? wa : (wovf ? '0 : wr);
			default:                w = (b[31:0] == '0) ? a[31:0] : a[31:0] % b[31:0];
		endcase
		if (op[2])
			r = {{32{w[31]}}, w}; // word results always sign-extend
		return r;
	endfunction

	task automatic start_test(input string name);
		test_name   = name;
		test_checks = 0;
		test_errors = 0;
		test_count++;
	endtask

	task automatic finish_test();
		if (outstanding != 0) begin
			$display("%0d results never arrived in test %s", outstanding, test_name);
			error_count++;
			test_errors++;
		end
		$display("test %s: %0d results checked, %0d errors", test_name, test_checks, test_errors);
	endtask

	task automatic report_counts();
		$display("%0d tests, %0d results checked, %0d errors", test_count, check_count,
			error_count);
	endtask

	// sampled mid-cycle, a handshake seen here transfers at the next rising edge
	always @(negedge clk) begin
		logic [`XLEN-1:0]  exp_r;
		logic [`TAG_W-1:0] exp_t;
		if (!reset) begin
			if (out_valid && out_ready) begin
				if (exp_tag.size() == 0) begin
					$display("unexpected result with tag %0h and value %h, nothing was pending",
						out_tag, out_result);
					error_count++;
					test_errors++;
				end else begin
					exp_r = exp_res.pop_front();
					exp_t = exp_tag.pop_front();
					check_count++;
					test_checks++;
					if (out_tag != exp_t || out_result != exp_r) begin
						$display("Fail %s: expected tag %0h result %h, actual tag %0h result %h",
							test_name, exp_t, exp_r, out_tag, out_result);
						error_count++;
						test_errors++;
					end
				end
			end
			if (flush) begin
				if (exp_tag.size() != 0)
					$display("flush dropped %0d pending results", exp_tag.size());
				exp_res.delete();
				exp_tag.delete();
			end else if (in_valid && in_ready) begin
				exp_res.push_back(div_ref(in_op, in_a, in_b));
				exp_tag.push_back(in_tag);
			end
			outstanding = exp_tag.size();
		end
	end

endmodule

/* div_unit_top.sv */
`include "div_unit_defs.svh"

module div_unit_top (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    flush,
	input  logic                    in_valid,
	output logic                    in_ready,
	input  div_unit_pkg::div_op_e   in_op,
	input  logic [`XLEN-1:0]        in_a,
	input  logic [`XLEN-1:0]        in_b,
	input  logic [`TAG_W-1:0]       in_tag,
	output logic                    out_valid,
	input  logic                    out_ready,
	output logic [`XLEN-1:0]        out_result,
	output logic [`TAG_W-1:0]       out_tag
);

	// queue to prep
	logic                  q_valid, q_ready;
	div_unit_pkg::div_op_e q_op;
	logic [`XLEN-1:0]      q_a, q_b;
	logic [`TAG_W-1:0]     q_tag;

	// prep to divider, plus sideband to formatter
	logic                  p_valid, p_ready, p_word;
	logic [`XLEN-1:0]      p_dividend, p_divisor, p_orig_a;
	div_unit_pkg::div_op_e p_op;
	logic [`TAG_W-1:0]     p_tag;
	logic                  p_neg_quot, p_neg_rem, p_div_zero, p_overflow;

	// divider to formatter
	logic                  d_valid, d_ready;
	logic [`XLEN-1:0]      d_quot, d_rem;

	div_req_queue queue_i (
		.clk, .reset, .flush,
		.in_valid, .in_ready, .in_op, .in_a, .in_b, .in_tag,
		.q_valid, .q_ready, .q_op, .q_a, .q_b, .q_tag
	);

	div_operand_prep prep_i (
		.clk, .reset, .flush,
		.q_valid, .q_ready, .q_op, .q_a, .q_b, .q_tag,
		.p_valid, .p_ready, .p_dividend, .p_divisor, .p_word,
		.p_op, .p_tag, .p_neg_quot, .p_neg_rem, .p_div_zero, .p_overflow, .p_orig_a
	);

	iterative_divider divider_i (
		.clk, .reset, .flush,
		.p_valid, .p_ready, .p_dividend, .p_divisor, .p_word,
		.d_valid, .d_ready, .d_quot, .d_rem
	);

	div_result_format format_i (
		.clk, .reset, .flush,
		.d_valid, .d_ready, .d_quot, .d_rem,
		.p_valid, .p_ready,
		.p_op, .p_tag, .p_neg_quot, .p_neg_rem, .p_div_zero, .p_overflow, .p_orig_a,
		.out_valid, .out_ready, .out_result, .out_tag
	);

endmodule

/* div_result_format.sv */
`include "div_unit_defs.svh"

module div_result_format (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    flush,
	input  logic                    d_valid,
	output logic                    d_ready,
	input  logic [`XLEN-1:0]        d_quot,
	input  logic [`XLEN-1:0]        d_rem,
	input  logic                    p_valid,
	input  logic                    p_ready,
	input  div_unit_pkg::div_op_e   p_op,
	input  logic [`TAG_W-1:0]       p_tag,
	input  logic                    p_neg_quot,
	input  logic                    p_neg_rem,
	input  logic                    p_div_zero,
	input  logic                    p_overflow,
	input  logic [`XLEN-1:0]        p_orig_a,
	output logic                    out_valid,
	input  logic                    out_ready,
	output logic [`XLEN-1:0]        out_result,
	output logic [`TAG_W-1:0]       out_tag
);

	// sideband of the op now in the divider
	div_unit_pkg::div_op_e sb_op;
	logic [`TAG_W-1:0]     sb_tag;
	logic                  sb_neg_quot;
	logic                  sb_neg_rem;
	logic                  sb_div_zero;
	logic                  sb_overflow;
	logic [`XLEN-1:0]      sb_orig_a;

	logic                  d_fire;
	logic                  is_rem;
	logic                  is_word;
	logic [`XLEN-1:0]      quot_fix;
	logic [`XLEN-1:0]      rem_fix;
	logic [`XLEN-1:0]      raw;
	logic [`XLEN-1:0]      result;

	assign d_ready = !out_valid || out_ready;
	assign d_fire  = d_valid && d_ready;

	always_ff @(posedge clk) begin
		if (p_valid && p_ready) begin // launch into the divider
			sb_op       <= p_op;
			sb_tag      <= p_tag;
			sb_neg_quot <= p_neg_quot;
			sb_neg_rem  <= p_neg_rem;
			sb_div_zero <= p_div_zero;
			sb_overflow <= p_overflow;
			sb_orig_a   <= p_orig_a;
		end
	end

	// ############################################################
	// sign fix, special cases, word extension
	// ############################################################
	always_comb begin
		is_rem   = sb_op[1]; // rem, remu, remw, remuw
		is_word  = sb_op[2];
		quot_fix = sb_neg_quot ? -d_quot : d_quot;
		rem_fix  = sb_neg_rem ? -d_rem : d_rem;
		if (sb_div_zero)
			raw = is_rem ? sb_orig_a : '1;
		else if (sb_overflow)
			raw = is_rem ? '0 : sb_orig_a;
		else
			raw = is_rem ? rem_fix : quot_fix;
		result = is_word ? {{(`XLEN-`WORD_W){raw[`WORD_W-1]}}, raw[`WORD_W-1:0]} : raw;
	end

	always_ff @(posedge clk) begin
		if (reset || flush)
			out_valid <= 1'b0;
		else if (d_ready)
			out_valid <= d_valid;
	end

	always_ff @(posedge clk) begin
		if (d_fire) begin
			out_result <= result;
			out_tag    <= sb_tag;
		end
	end

endmodule

/* iterative_divider.sv */
`include "div_unit_defs.svh"

module iterative_divider (
	input  logic               clk,
	input  logic               reset,
	input  logic               flush,
	input  logic               p_valid,
	output logic               p_ready,
	input  logic [`XLEN-1:0]   p_dividend,
	input  logic [`XLEN-1:0]   p_divisor,
	input  logic               p_word,
	output logic               d_valid,
	input  logic               d_ready,
	output logic [`XLEN-1:0]   d_quot,
	output logic [`XLEN-1:0]   d_rem
);

	div_unit_pkg::div_state_e state;

	logic [2*`XLEN-1:0] rem_acc; // partial remainder over shifting dividend
	logic [`XLEN-1:0]   divisor_r;
	logic [`XLEN-1:0]   quot_sr;
	logic [`CNT_W-1:0]  cnt;
	logic [`CNT_W-1:0]  last_cnt;
	logic               word_r;
	logic [`XLEN:0]     part_sub; // sign bit tells if the trial fits
	logic               launch;

	assign p_ready = (state == div_unit_pkg::div_idle);
	assign d_valid = (state == div_unit_pkg::div_done);
	assign launch  = p_valid && p_ready;

	assign last_cnt = word_r ? `CNT_W'(`WORD_W - 1) : `CNT_W'(`XLEN - 1);
	assign part_sub = rem_acc[2*`XLEN-1:`XLEN-1] - {1'b0, divisor_r};

	assign d_quot = quot_sr;
	assign d_rem  = rem_acc[2*`XLEN-1:`XLEN];

	// ############################################################
	// control
	// ############################################################
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			state <= div_unit_pkg::div_idle;
		end else begin
			case (state)
				div_unit_pkg::div_idle:
					if (launch)
						state <= div_unit_pkg::div_busy;
				div_unit_pkg::div_busy:
					if (cnt == last_cnt)
						state <= div_unit_pkg::div_done;
				div_unit_pkg::div_done:
					if (d_ready)
						state <= div_unit_pkg::div_idle;
				default:
					state <= div_unit_pkg::div_idle;
			endcase
		end
	end

	// datapath, one quotient bit per busy cycle
	always_ff @(posedge clk) begin
		if (launch) begin
			rem_acc   <= {{`XLEN{1'b0}}, p_dividend};
			divisor_r <= p_divisor;
			word_r    <= p_word;
			quot_sr   <= '0;
			cnt       <= '0;
		end else if (state == div_unit_pkg::div_busy) begin
			if (!part_sub[`XLEN]) begin
				rem_acc <= {part_sub[`XLEN-1:0], rem_acc[`XLEN-2:0], 1'b0};
				quot_sr <= {quot_sr[`XLEN-2:0], 1'b1};
			end else begin
				rem_acc <= {rem_acc[2*`XLEN-2:0], 1'b0};
				quot_sr <= {quot_sr[`XLEN-2:0], 1'b0};
			end
			cnt <= cnt + 1'b1;
		end
	end

endmodule

/* div_operand_prep.sv */
`include "div_unit_defs.svh"

module div_operand_prep (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    flush,
	input  logic                    q_valid,
	output logic                    q_ready,
	input  div_unit_pkg::div_op_e   q_op,
	input  logic [`XLEN-1:0]        q_a,
	input  logic [`XLEN-1:0]        q_b,
	input  logic [`TAG_W-1:0]       q_tag,
	output logic                    p_valid,
	input  logic                    p_ready,
	output logic [`XLEN-1:0]        p_dividend,
	output logic [`XLEN-1:0]        p_divisor,
	output logic                    p_word,
	output div_unit_pkg::div_op_e   p_op,
	output logic [`TAG_W-1:0]       p_tag,
	output logic                    p_neg_quot,
	output logic                    p_neg_rem,
	output logic                    p_div_zero,
	output logic                    p_overflow,
	output logic [`XLEN-1:0]        p_orig_a
);

	logic                is_signed;
	logic                is_word;
	logic                a_neg;
	logic                b_neg;
	logic [`XLEN-1:0]    a_mag;
	logic [`XLEN-1:0]    b_mag;
	logic [`WORD_W-1:0]  a_lo_mag;
	logic [`WORD_W-1:0]  b_lo_mag;
	logic [`XLEN-1:0]    dividend;
	logic [`XLEN-1:0]    divisor;
	logic                div_zero;
	logic                overflow;
	logic                q_fire;

	// one-entry stage, refills in the cycle it drains
	assign q_ready = !p_valid || p_ready;
	assign q_fire  = q_valid && q_ready;

	// ############################################################
	// magnitudes and flags
	// ############################################################
	always_comb begin
		is_signed = (q_op == div_unit_pkg::op_div) || (q_op == div_unit_pkg::op_rem) ||
			(q_op == div_unit_pkg::op_divw) || (q_op == div_unit_pkg::op_remw);
		is_word = q_op[2]; // upper half of the encoding is the word forms

		a_neg = is_signed && (is_word ? q_a[`WORD_W-1] : q_a[`XLEN-1]);
		b_neg = is_signed && (is_word ? q_b[`WORD_W-1] : q_b[`XLEN-1]);

		a_mag    = a_neg ? -q_a : q_a;
		b_mag    = b_neg ? -q_b : q_b;
		a_lo_mag = a_neg ? -q_a[`WORD_W-1:0] : q_a[`WORD_W-1:0];
		b_lo_mag = b_neg ? -q_b[`WORD_W-1:0] : q_b[`WORD_W-1:0];

		// word dividend sits in the top half so 32 steps are enough
		dividend = is_word ? {a_lo_mag, {`WORD_W{1'b0}}} : a_mag;
		divisor  = is_word ? {{(`XLEN-`WORD_W){1'b0}}, b_lo_mag} : b_mag;

		div_zero = is_word ? (q_b[`WORD_W-1:0] == '0) : (q_b == '0);
		// most negative / -1
		overflow = is_signed && (is_word ?
			((q_a[`WORD_W-1:0] == {1'b1, {(`WORD_W-1){1'b0}}}) && (&q_b[`WORD_W-1:0])) :
			((q_a == {1'b1, {(`XLEN-1){1'b0}}}) && (&q_b)));
	end

	always_ff @(posedge clk) begin
		if (reset || flush)
			p_valid <= 1'b0;
		else if (q_ready)
			p_valid <= q_valid;
	end

	always_ff @(posedge clk) begin
		if (q_fire) begin
			p_dividend <= dividend;
			p_divisor  <= divisor;
			p_word     <= is_word;
			p_op       <= q_op;
			p_tag      <= q_tag;
			p_neg_quot <= a_neg ^ b_neg; // both already gated by signedness
			p_neg_rem  <= a_neg; // remainder follows the dividend
			p_div_zero <= div_zero;
			p_overflow <= overflow;
			p_orig_a   <= q_a;
		end
	end

endmodule

/* div_req_queue.sv */
`include "div_unit_defs.svh"

module div_req_queue (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    flush,
	input  logic                    in_valid,
	output logic                    in_ready,
	input  div_unit_pkg::div_op_e   in_op,
	input  logic [`XLEN-1:0]        in_a,
	input  logic [`XLEN-1:0]        in_b,
	input  logic [`TAG_W-1:0]       in_tag,
	output logic                    q_valid,
	input  logic                    q_ready,
	output div_unit_pkg::div_op_e   q_op,
	output logic [`XLEN-1:0]        q_a,
	output logic [`XLEN-1:0]        q_b,
	output logic [`TAG_W-1:0]       q_tag
);

	// storage, one slot per request
	div_unit_pkg::div_op_e   op_mem  [`QUEUE_DEPTH];
	logic [`XLEN-1:0]        a_mem   [`QUEUE_DEPTH];
	logic [`XLEN-1:0]        b_mem   [`QUEUE_DEPTH];
	logic [`TAG_W-1:0]       tag_mem [`QUEUE_DEPTH];

	logic [`QUEUE_PTR_W-1:0] wr_ptr;
	logic [`QUEUE_PTR_W-1:0] rd_ptr;
	logic [`QUEUE_PTR_W:0]   count; // one extra bit to tell full from empty

	logic wr_en;
	logic rd_en;

	assign in_ready = (count != (`QUEUE_PTR_W+1)'(`QUEUE_DEPTH));
	assign q_valid  = (count != '0);

	assign wr_en = in_valid && in_ready;
	assign rd_en = q_valid && q_ready;

	// head of queue goes straight out
	assign q_op  = op_mem[rd_ptr];
	assign q_a   = a_mem[rd_ptr];
	assign q_b   = b_mem[rd_ptr];
	assign q_tag = tag_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en) begin
			op_mem[wr_ptr]  <= in_op;
			a_mem[wr_ptr]   <= in_a;
			b_mem[wr_ptr]   <= in_b;
			tag_mem[wr_ptr] <= in_tag;
		end
	end

	// ############################################################
	// pointers and occupancy
	// ############################################################
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1; // wraps on power of two depth
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous read and write leaves count alone
			if (wr_en && !rd_en)
				count <= count + 1'b1;
			else if (rd_en && !wr_en)
				count <= count - 1'b1;
		end
	end

endmodule

/* div_unit_pkg.sv */
package div_unit_pkg;

	// ############################################################
	// M-extension divide opcodes
	// ############################################################
	typedef enum logic [2:0] {
		op_div   = 3'd0,
		op_divu  = 3'd1,
		op_rem   = 3'd2,
		op_remu  = 3'd3,
		op_divw  = 3'd4, // word forms from here on
		op_divuw = 3'd5,
		op_remw  = 3'd6,
		op_remuw = 3'd7
	} div_op_e;

	// ############################################################
	// divider control
	// ############################################################
	typedef enum logic [1:0] {
		div_idle = 2'd0,
		div_busy = 2'd1,
		div_done = 2'd2
	} div_state_e;

endpackage

/* div_unit_defs.svh */
`ifndef DIV_UNIT_DEFS_SVH
`define DIV_UNIT_DEFS_SVH

// operand and result width
`define XLEN 64

// low half used by the word forms
`define WORD_W 32

// request queue depth, power of two
`define QUEUE_DEPTH 4
`define QUEUE_PTR_W 2

// request tag carried through to the result
`define TAG_W 4

// iteration counter, must hold XLEN
`define CNT_W 7

`endif
